// File: sdram_subsystem.f
design/sdram_bus_pkg.sv
design/sdram_master_pkg.sv
design/sdram_controller.sv
design/sdram_arbiter.sv
design/sdram_subsystem.sv
test/sdram_subsystem_assert.sv
test/sdram_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= sdram_subsystem_tb
FILELIST  ?= sdram_subsystem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/sdram_subsystem_tb.sv
module sdram_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import sdram_bus_pkg::*;
    import sdram_master_pkg::*;

    localparam int MEM_WORDS    = 1024;
    localparam int READ_LATENCY = 3;
    localparam int N_ROWS       = 29;
    localparam int TIMEOUT      = N_ROWS * (READ_LATENCY + BURST_WORDS + 8) * NUM_MASTERS;

    logic  clk;
    logic  reset;
    logic  req [1:4];
    logic  wr [1:4];
    logic  bst [1:4];
    addr_t addr [1:4];
    data_t wdata [1:4];
    strb_t wstrb [1:4];
    logic  ready [1:4];
    logic  rvalid [1:4];
    addr_t raddr [1:4];
    data_t rdata [1:4];
    logic  complete [1:4];

    // Stimulus table, one command per master per row
    bit    t_req [N_ROWS][1:4];
    bit    t_wr [N_ROWS][1:4];
    bit    t_bst [N_ROWS][1:4];
    addr_t t_addr [N_ROWS][1:4];
    data_t t_wdata [N_ROWS][1:4];
    strb_t t_wstrb [N_ROWS][1:4];

    data_t       ref_mem [MEM_WORDS];
    bit          pending [1:4];
    addr_t       exp_addr [1:4][BURST_WORDS];
    data_t       exp_data [1:4][BURST_WORDS];
    int          exp_cnt [1:4];
    int          exp_pos [1:4];
    int          exp_first [1:4];           // Cycle of the first read word
    int          cyc;
    int          errors;
    int unsigned lcg_state;

    sdram_subsystem #(.MEM_WORDS(MEM_WORDS), .READ_LATENCY(READ_LATENCY)) dut0 (
        .clk(clk), .reset(reset),
        .m1_request(req[1]), .m1_write(wr[1]), .m1_burst(bst[1]), .m1_address(addr[1]),
        .m1_wdata(wdata[1]), .m1_wstrb(wstrb[1]), .m1_ready(ready[1]),
        .m1_rvalid(rvalid[1]), .m1_raddress(raddr[1]), .m1_rdata(rdata[1]),
        .m1_complete(complete[1]),
        .m2_request(req[2]), .m2_write(wr[2]), .m2_burst(bst[2]), .m2_address(addr[2]),
        .m2_wdata(wdata[2]), .m2_wstrb(wstrb[2]), .m2_ready(ready[2]),
        .m2_rvalid(rvalid[2]), .m2_raddress(raddr[2]), .m2_rdata(rdata[2]),
        .m2_complete(complete[2]),
        .m3_request(req[3]), .m3_write(wr[3]), .m3_burst(bst[3]), .m3_address(addr[3]),
        .m3_wdata(wdata[3]), .m3_wstrb(wstrb[3]), .m3_ready(ready[3]),
        .m3_rvalid(rvalid[3]), .m3_raddress(raddr[3]), .m3_rdata(rdata[3]),
        .m3_complete(complete[3]),
        .m4_request(req[4]), .m4_write(wr[4]), .m4_burst(bst[4]), .m4_address(addr[4]),
        .m4_wdata(wdata[4]), .m4_wstrb(wstrb[4]), .m4_ready(ready[4]),
        .m4_rvalid(rvalid[4]), .m4_raddress(raddr[4]), .m4_rdata(rdata[4]),
        .m4_complete(complete[4])
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT) begin
            $display("Run timed out after %0d cycles", cyc);
            $display("Errors: %0d", errors);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int word_of(input addr_t a);
        return (a / 4) % MEM_WORDS;
    endfunction

    task automatic set_cmd(input int r, input int m, input bit w, input bit b,
                           input addr_t a, input data_t d, input strb_t s);
        t_req[r][m]   = 1'b1;
        t_wr[r][m]    = w;
        t_bst[r][m]   = b;
        t_addr[r][m]  = a;
        t_wdata[r][m] = d;
        t_wstrb[r][m] = s;
    endtask

    task automatic build_table();
        // Row 0 stays idle
        for (int m = 1; m <= 4; m++) begin
            set_cmd(m, m, 1'b1, 1'b0, addr_t'(m * 16), 32'hA5A50000 + m, 4'hF);
            set_cmd(m + 4, m, 1'b0, 1'b0, addr_t'(m * 16), '0, '0);
        end
        set_cmd(9, 3, 1'b1, 1'b0, 26'h30, 32'h11223344, 4'b0101);
        set_cmd(10, 1, 1'b1, 1'b1, 26'h10, 32'hDEADBEEF, 4'b1000);  // Burst flag ignored
        set_cmd(11, 1, 1'b0, 1'b0, 26'h10, '0, '0);
        set_cmd(11, 3, 1'b0, 1'b0, 26'h30, '0, '0);
        set_cmd(11, 4, 1'b0, 1'b0, 26'h40, '0, '0);
        for (int k = 0; k < BURST_WORDS; k++) begin
            set_cmd(12 + k, 1, 1'b1, 1'b0, addr_t'(26'h200 + 4 * k), lcg_next(), 4'hF);
        end
        set_cmd(28, 2, 1'b0, 1'b1, 26'h224, '0, '0);              // Unaligned burst
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
        errors++;
    endtask

    // Grants and read returns seen in the middle of a cycle
    task automatic check_cycle();
        int    lowest;
        addr_t a;
        lowest = 0;
        for (int m = 4; m >= 1; m--) begin
            if (pending[m]) lowest = m;
        end
        for (int m = 1; m <= 4; m++) begin
            if (ready[m] && !pending[m]) begin
                $display("Master %0d granted without a request at %0t", m, $time);
                errors++;
            end else if (ready[m]) begin
                if (m != lowest) begin
                    $display("Master %0d granted ahead of master %0d at %0t", m, lowest, $time);
                    errors++;
                end
                pending[m] = 1'b0;
                if (wr[m]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[m][b]) ref_mem[word_of(addr[m])][8*b +: 8] = wdata[m][8*b +: 8];
                    end
                end else begin
                    a = bst[m] ? addr_t'(addr[m] - addr[m] % BURST_BYTES) : addr[m];
                    exp_cnt[m]   = bst[m] ? BURST_WORDS : 1;
                    exp_pos[m]   = 0;
                    exp_first[m] = cyc + 1 + READ_LATENCY + 1;
                    for (int k = 0; k < exp_cnt[m]; k++) begin
                        exp_addr[m][k] = a + addr_t'(4 * k);
                        exp_data[m][k] = ref_mem[word_of(a + addr_t'(4 * k))];
                    end
                end
            end
            if (rvalid[m]) begin
                if (exp_pos[m] >= exp_cnt[m]) begin
                    $display("Master %0d got read data it did not ask for at %0t", m, $time);
                    errors++;
                end else begin
                    if (cyc != exp_first[m] + exp_pos[m])
                        report_mismatch($sformatf("m%0d_rvalid cycle", m),
                                        exp_first[m] + exp_pos[m], cyc);
                    if (raddr[m] !== exp_addr[m][exp_pos[m]])
                        report_mismatch($sformatf("m%0d_raddress", m),
                                        32'(exp_addr[m][exp_pos[m]]), 32'(raddr[m]));
                    if (rdata[m] !== exp_data[m][exp_pos[m]])
                        report_mismatch($sformatf("m%0d_rdata", m),
                                        exp_data[m][exp_pos[m]], rdata[m]);
                    if (complete[m] !== (exp_pos[m] == exp_cnt[m] - 1))
                        report_mismatch($sformatf("m%0d_complete", m),
                                        32'(exp_pos[m] == exp_cnt[m] - 1), 32'(complete[m]));
                    exp_pos[m]++;
                end
            end else if (exp_pos[m] < exp_cnt[m] && cyc >= exp_first[m] + exp_pos[m]) begin
                $display("Master %0d missed read word %0d at %0t", m, exp_pos[m], $time);
                errors++;
                exp_pos[m] = exp_cnt[m];
            end
        end
    endtask

    task automatic run_row(input int r);
        int n_cyc;
        bit busy;
        @(posedge clk);
        for (int m = 1; m <= 4; m++) begin
            if (t_req[r][m]) begin
                req[m]     <= 1'b1;
                wr[m]      <= t_wr[r][m];
                bst[m]     <= t_bst[r][m];
                addr[m]    <= t_addr[r][m];
                wdata[m]   <= t_wdata[r][m];
                wstrb[m]   <= t_wstrb[r][m];
                pending[m] = 1'b1;
            end
        end
        n_cyc = 0;
        busy  = 1'b1;
        while (busy || n_cyc < 4) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            busy = 1'b0;
            for (int m = 1; m <= 4; m++) begin
                if (!pending[m]) req[m] <= 1'b0;   // Request drops after its grant edge
                if (pending[m] || exp_pos[m] < exp_cnt[m]) busy = 1'b1;
            end
            n_cyc++;
        end
    endtask

    initial begin
        reset     = 1'b1;
        cyc       = 0;
        errors    = 0;
        lcg_state = 32;
        for (int m = 1; m <= 4; m++) begin
            req[m]     = 1'b0;
            wr[m]      = 1'b0;
            bst[m]     = 1'b0;
            addr[m]    = '0;
            wdata[m]   = '0;
            wstrb[m]   = '0;
            pending[m] = 1'b0;
            exp_cnt[m] = 0;
            exp_pos[m] = 0;
        end
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < N_ROWS; r++) run_row(r);
        repeat (4) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: test/sdram_subsystem_assert.sv
module sdram_arbiter_assert (
    input logic clk,
    input logic reset,
    input logic m1_request,
    input logic m2_request,
    input logic m3_request,
    input logic m4_request,
    input logic m1_ready,
    input logic m2_ready,
    input logic m3_ready,
    input logic m4_ready,
    input logic m1_rvalid,
    input logic m2_rvalid,
    input logic m3_rvalid,
    input logic m4_rvalid,
    input logic sdram_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({m1_ready, m2_ready, m3_ready, m4_ready}))
        else $error("More than one master granted");

    a_grant_needs_request: assert property (@(posedge clk) disable iff (reset)
        (!m1_ready || m1_request) && (!m2_ready || m2_request) &&
        (!m3_ready || m3_request) && (!m4_ready || m4_request))
        else $error("Grant given to a master that is not requesting");

    a_grant_needs_port: assert property (@(posedge clk) disable iff (reset)
        !sdram_ready |-> !(m1_ready || m2_ready || m3_ready || m4_ready))
        else $error("Grant given while the controller is busy");

    a_one_rvalid: assert property (@(posedge clk) disable iff (reset)
        $onehot0({m1_rvalid, m2_rvalid, m3_rvalid, m4_rvalid}))
        else $error("Read data steered to more than one master");

endmodule

bind sdram_arbiter sdram_arbiter_assert u_arb_assert (.*);

// File: design/sdram_subsystem.sv
module sdram_subsystem #(
    parameter int MEM_WORDS    = 1024,
    parameter int READ_LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 m1_request,
    input  logic                 m1_write,
    input  logic                 m1_burst,
    input  sdram_bus_pkg::addr_t m1_address,
    input  sdram_bus_pkg::data_t m1_wdata,
    input  sdram_bus_pkg::strb_t m1_wstrb,
    output logic                 m1_ready,
    output logic                 m1_rvalid,
    output sdram_bus_pkg::addr_t m1_raddress,
    output sdram_bus_pkg::data_t m1_rdata,
    output logic                 m1_complete,

    input  logic                 m2_request,
    input  logic                 m2_write,
    input  logic                 m2_burst,
    input  sdram_bus_pkg::addr_t m2_address,
    input  sdram_bus_pkg::data_t m2_wdata,
    input  sdram_bus_pkg::strb_t m2_wstrb,
    output logic                 m2_ready,
    output logic                 m2_rvalid,
    output sdram_bus_pkg::addr_t m2_raddress,
    output sdram_bus_pkg::data_t m2_rdata,
    output logic                 m2_complete,

    input  logic                 m3_request,
    input  logic                 m3_write,
    input  logic                 m3_burst,
    input  sdram_bus_pkg::addr_t m3_address,
    input  sdram_bus_pkg::data_t m3_wdata,
    input  sdram_bus_pkg::strb_t m3_wstrb,
    output logic                 m3_ready,
    output logic                 m3_rvalid,
    output sdram_bus_pkg::addr_t m3_raddress,
    output sdram_bus_pkg::data_t m3_rdata,
    output logic                 m3_complete,

    input  logic                 m4_request,
    input  logic                 m4_write,
    input  logic                 m4_burst,
    input  sdram_bus_pkg::addr_t m4_address,
    input  sdram_bus_pkg::data_t m4_wdata,
    input  sdram_bus_pkg::strb_t m4_wstrb,
    output logic                 m4_ready,
    output logic                 m4_rvalid,
    output sdram_bus_pkg::addr_t m4_raddress,
    output sdram_bus_pkg::data_t m4_rdata,
    output logic                 m4_complete
);
    import sdram_bus_pkg::*;
    import sdram_master_pkg::*;

    master_id_t sdram_request;              // Registered command
    addr_t      sdram_address;
    logic       sdram_write;
    logic       sdram_burst;
    strb_t      sdram_wstrb;
    data_t      sdram_wdata;
    logic       sdram_ready;
    addr_t      sdram_raddress;             // Read return
    data_t      sdram_rdata;
    master_id_t sdram_rvalid;
    logic       sdram_complete;

    // Port names match the wires one to one
    sdram_arbiter arb0 (.*);

    sdram_controller #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) ctrl0 (.*);

endmodule

// File: design/sdram_arbiter.sv
module sdram_arbiter (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         m1_request,     // Master 1 wants the port
    input  logic                         m1_write,       // 1 write, 0 read
    input  logic                         m1_burst,       // 64 byte block read
    input  sdram_bus_pkg::addr_t         m1_address,
    input  sdram_bus_pkg::data_t         m1_wdata,
    input  sdram_bus_pkg::strb_t         m1_wstrb,
    output logic                         m1_ready,       // Grant, same cycle
    output logic                         m1_rvalid,
    output sdram_bus_pkg::addr_t         m1_raddress,
    output sdram_bus_pkg::data_t         m1_rdata,
    output logic                         m1_complete,    // Last word of the read

    input  logic                         m2_request,
    input  logic                         m2_write,
    input  logic                         m2_burst,
    input  sdram_bus_pkg::addr_t         m2_address,
    input  sdram_bus_pkg::data_t         m2_wdata,
    input  sdram_bus_pkg::strb_t         m2_wstrb,
    output logic                         m2_ready,
    output logic                         m2_rvalid,
    output sdram_bus_pkg::addr_t         m2_raddress,
    output sdram_bus_pkg::data_t         m2_rdata,
    output logic                         m2_complete,

    input  logic                         m3_request,
    input  logic                         m3_write,
    input  logic                         m3_burst,
    input  sdram_bus_pkg::addr_t         m3_address,
    input  sdram_bus_pkg::data_t         m3_wdata,
    input  sdram_bus_pkg::strb_t         m3_wstrb,
    output logic                         m3_ready,
    output logic                         m3_rvalid,
    output sdram_bus_pkg::addr_t         m3_raddress,
    output sdram_bus_pkg::data_t         m3_rdata,
    output logic                         m3_complete,

    input  logic                         m4_request,
    input  logic                         m4_write,
    input  logic                         m4_burst,
    input  sdram_bus_pkg::addr_t         m4_address,
    input  sdram_bus_pkg::data_t         m4_wdata,
    input  sdram_bus_pkg::strb_t         m4_wstrb,
    output logic                         m4_ready,
    output logic                         m4_rvalid,
    output sdram_bus_pkg::addr_t         m4_raddress,
    output sdram_bus_pkg::data_t         m4_rdata,
    output logic                         m4_complete,

    output sdram_master_pkg::master_id_t sdram_request,  // Granted master, one cycle
    output sdram_bus_pkg::addr_t         sdram_address,
    output logic                         sdram_write,
    output logic                         sdram_burst,
    output sdram_bus_pkg::strb_t         sdram_wstrb,
    output sdram_bus_pkg::data_t         sdram_wdata,
    input  logic                         sdram_ready,    // Controller can take a command
    input  sdram_bus_pkg::addr_t         sdram_raddress,
    input  sdram_bus_pkg::data_t         sdram_rdata,
    input  sdram_master_pkg::master_id_t sdram_rvalid,   // Destination of this word
    input  logic                         sdram_complete
);
    import sdram_bus_pkg::*;
    import sdram_master_pkg::*;

    master_id_t next_request;
    addr_t      next_address;
    logic       next_write;
    logic       next_burst;
    strb_t      next_wstrb;
    data_t      next_wdata;

    // Fixed priority, master 1 first
    always_comb begin
        next_request = MID_NONE;            // Command lasts one cycle
        next_address = sdram_address;       // Fields hold between grants
        next_write   = sdram_write;
        next_burst   = sdram_burst;
        next_wstrb   = sdram_wstrb;
        next_wdata   = sdram_wdata;
        m1_ready     = 1'b0;
        m2_ready     = 1'b0;
        m3_ready     = 1'b0;
        m4_ready     = 1'b0;
        if (sdram_ready) begin
            if (m1_request) begin
                next_request = MID_M1;
                next_address = m1_address;
                next_write   = m1_write;
                next_burst   = m1_burst;
                next_wstrb   = m1_wstrb;
                next_wdata   = m1_wdata;
                m1_ready     = 1'b1;
            end else if (m2_request) begin
                next_request = MID_M2;
                next_address = m2_address;
                next_write   = m2_write;
                next_burst   = m2_burst;
                next_wstrb   = m2_wstrb;
                next_wdata   = m2_wdata;
                m2_ready     = 1'b1;
            end else if (m3_request) begin
                next_request = MID_M3;
                next_address = m3_address;
                next_write   = m3_write;
                next_burst   = m3_burst;
                next_wstrb   = m3_wstrb;
                next_wdata   = m3_wdata;
                m3_ready     = 1'b1;
            end else if (m4_request) begin
                next_request = MID_M4;
                next_address = m4_address;
                next_write   = m4_write;
                next_burst   = m4_burst;
                next_wstrb   = m4_wstrb;
                next_wdata   = m4_wdata;
                m4_ready     = 1'b1;
            end else begin
                next_address = '0;          // Idle bus
                next_write   = 1'b0;
                next_burst   = 1'b0;
                next_wstrb   = '0;
                next_wdata   = '0;
            end
        end
    end

    // Steer each returned word to the tagged master only
    always_comb begin
        m1_rvalid   = 1'b0;
        m1_raddress = '0;
        m1_rdata    = '0;
        m1_complete = 1'b0;
        m2_rvalid   = 1'b0;
        m2_raddress = '0;
        m2_rdata    = '0;
        m2_complete = 1'b0;
        m3_rvalid   = 1'b0;
        m3_raddress = '0;
        m3_rdata    = '0;
        m3_complete = 1'b0;
        m4_rvalid   = 1'b0;
        m4_raddress = '0;
        m4_rdata    = '0;
        m4_complete = 1'b0;
        case (sdram_rvalid)
            MID_M1: begin
                m1_rvalid   = 1'b1;
                m1_raddress = sdram_raddress;
                m1_rdata    = sdram_rdata;
                m1_complete = sdram_complete;
            end
            MID_M2: begin
                m2_rvalid   = 1'b1;
                m2_raddress = sdram_raddress;
                m2_rdata    = sdram_rdata;
                m2_complete = sdram_complete;
            end
            MID_M3: begin
                m3_rvalid   = 1'b1;
                m3_raddress = sdram_raddress;
                m3_rdata    = sdram_rdata;
                m3_complete = sdram_complete;
            end
            MID_M4: begin
                m4_rvalid   = 1'b1;
                m4_raddress = sdram_raddress;
                m4_rdata    = sdram_rdata;
                m4_complete = sdram_complete;
            end
            default: ;                      // MID_NONE or unused code
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sdram_request <= MID_NONE;
            sdram_address <= '0;
            sdram_write   <= 1'b0;
            sdram_burst   <= 1'b0;
            sdram_wstrb   <= '0;
            sdram_wdata   <= '0;
        end else begin
            sdram_request <= next_request;
            sdram_address <= next_address;
            sdram_write   <= next_write;
            sdram_burst   <= next_burst;
            sdram_wstrb   <= next_wstrb;
            sdram_wdata   <= next_wdata;
        end
    end

endmodule

// File: design/sdram_controller.sv
module sdram_controller #(
    parameter int MEM_WORDS    = 1024,      // Model size in words
    parameter int READ_LATENCY = 3          // Accept to first word, at least 1
) (
    input  logic                         clk,
    input  logic                         reset,

    input  sdram_master_pkg::master_id_t sdram_request,  // Nonzero for one cycle
    input  sdram_bus_pkg::addr_t         sdram_address,
    input  logic                         sdram_write,
    input  logic                         sdram_burst,    // Ignored on writes
    input  sdram_bus_pkg::strb_t         sdram_wstrb,
    input  sdram_bus_pkg::data_t         sdram_wdata,

    output logic                         sdram_ready,
    output sdram_bus_pkg::addr_t         sdram_raddress,
    output sdram_bus_pkg::data_t         sdram_rdata,
    output sdram_master_pkg::master_id_t sdram_rvalid,
    output logic                         sdram_complete
);
    import sdram_bus_pkg::*;
    import sdram_master_pkg::*;

    localparam int WORD_BYTES = $bits(data_t) / 8;
    localparam int IDX_W      = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int LAT_W      = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;
    localparam int BEAT_W     = $clog2(BURST_WORDS);

    typedef enum logic [1:0] {
        ST_IDLE,                            // Waiting for a command
        ST_WAIT,                            // Counting out read latency
        ST_STREAM                           // One word per cycle
    } state_t;

    state_t           state;
    logic [LAT_W-1:0] lat_cnt;
    logic [BEAT_W-1:0] beat_cnt;
    master_id_t       req_id;               // Owner of the read in flight
    addr_t            cur_addr;             // Address of the word on the bus
    logic             burst_q;
    logic             accept;
    logic             last_beat;

    data_t mem [MEM_WORDS];

    // Word index from the bits above the byte offset, wrapped to the array
    function automatic logic [IDX_W-1:0] word_index(input addr_t addr);
        return IDX_W'((addr / WORD_BYTES) % MEM_WORDS);
    endfunction

    function automatic addr_t block_base(input addr_t addr);
        return addr & ~addr_t'(BURST_BYTES - 1);
    endfunction

    // Arbiter only presents a command while ready was high
    assign accept      = (state == ST_IDLE) && (sdram_request != MID_NONE);
    assign sdram_ready = (state == ST_IDLE) && (sdram_request == MID_NONE);

    assign last_beat = !burst_q || (beat_cnt == BEAT_W'(BURST_WORDS - 1));

    assign sdram_rvalid   = (state == ST_STREAM) ? req_id : MID_NONE;
    assign sdram_complete = (state == ST_STREAM) && last_beat;
    assign sdram_raddress = cur_addr;
    assign sdram_rdata    = mem[word_index(cur_addr)];

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            lat_cnt  <= '0;
            beat_cnt <= '0;
            req_id   <= MID_NONE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept && !sdram_write) begin
                        state    <= ST_WAIT;
                        lat_cnt  <= LAT_W'(READ_LATENCY - 1);
                        beat_cnt <= '0;
                        req_id   <= sdram_request;
                    end                     // Writes finish at accept
                end
                ST_WAIT: begin
                    if (lat_cnt == '0) begin
                        state <= ST_STREAM;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                ST_STREAM: begin
                    if (last_beat) begin
                        state  <= ST_IDLE;
                        req_id <= MID_NONE;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Read address walks the aligned block for a burst
    always_ff @(posedge clk) begin
        if (accept && !sdram_write) begin
            burst_q  <= sdram_burst;
            cur_addr <= sdram_burst ? block_base(sdram_address) : sdram_address;
        end else if (state == ST_STREAM && !last_beat) begin
            cur_addr <= cur_addr + addr_t'(WORD_BYTES);
        end
    end

    // Byte merge of a single-word write
    always_ff @(posedge clk) begin
        if (accept && sdram_write) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (sdram_wstrb[b]) begin
                    mem[word_index(sdram_address)][8*b +: 8] <= sdram_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: design/sdram_master_pkg.sv
package sdram_master_pkg;

    localparam int NUM_MASTERS = 4;         // Masters sharing the port

    // Tags a command on sdram_request and its data on sdram_rvalid
    typedef logic [2:0] master_id_t;

    localparam master_id_t MID_NONE = 3'd0; // No command, no data
    localparam master_id_t MID_M1   = 3'd1; // Highest priority
    localparam master_id_t MID_M2   = 3'd2;
    localparam master_id_t MID_M3   = 3'd3;
    localparam master_id_t MID_M4   = 3'd4; // Lowest priority

endpackage

// File: design/sdram_bus_pkg.sv
package sdram_bus_pkg;

    localparam int ADDR_W = 26;             // Byte address width
    localparam int DATA_W = 32;             // One memory word
    localparam int STRB_W = DATA_W / 8;     // One strobe bit per byte

    typedef logic [ADDR_W-1:0] addr_t;      // Byte address
    typedef logic [DATA_W-1:0] data_t;      // Data word
    typedef logic [STRB_W-1:0] strb_t;      // Byte write strobe

    // A burst read returns one aligned block of this many words
    localparam int BURST_WORDS = 16;
    localparam int BURST_BYTES = 64;        // Block size and alignment

endpackage
